/* sim.f */
verilog/glb_pkg.sv
verilog/memory_bank.sv
verilog/host_bank_interconnect.sv
verilog/io_stream_channel.sv
verilog/glb_config_ctrl.sv
verilog/global_buffer.sv
verif/tb_global_buffer.sv

/* verif/tb_global_buffer.sv */
/* Directed testbench for the global buffer that checks host access, configuration
   registers and CGRA streams against a bank word reference model. */
`timescale 1ns/1ps
`default_nettype none

module tb_global_buffer;

    import glb_pkg::*;

    localparam int        CLK_PERIOD    = 20;
    localparam int        MEM_WORDS     = 2 ** GLB_ADDR_WIDTH;
    localparam int        BANK_WORDS    = 2 ** BANK_ADDR_WIDTH;
    localparam int        LANES         = 2 ** LANE_WIDTH;
    localparam int        STREAM_WORDS  = 40 + 100 + 30 + 24;
    localparam int        HOST_ACCESSES = MEM_WORDS + 100 + 16 + 24;
    localparam int        WATCHDOG_NS   = (STREAM_WORDS + HOST_ACCESSES + 200) * CLK_PERIOD * 4;
    localparam cfg_data_t STREAM_MASK   = cfg_data_t'((1 << STREAM_ADDR_WIDTH) - 1);

    logic       clk;
    logic       rst_n;
    logic       host_wr_en;
    glb_addr_t  host_wr_addr;
    bank_data_t host_wr_data;
    logic       host_rd_en;
    glb_addr_t  host_rd_addr;
    bank_data_t host_rd_data;
    logic       cgra_start_pulse;
    logic       cgra_to_io_stall;
    cgra_data_t io_to_cgra_rd_data;
    logic       io_to_cgra_rd_data_valid;
    logic       top_config_wr;
    logic       top_config_rd;
    cfg_addr_t  top_config_addr;
    cfg_data_t  top_config_wr_data;
    cfg_data_t  top_config_rd_data;

    // reference copy of every bank word by global address
    bank_data_t model [MEM_WORDS];
    int         check_count;
    int         mismatch_count;
    int         protocol_errors;

    global_buffer #(
        .NUM_BANKS       (NUM_BANKS),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
        .BANK_DATA_WIDTH (BANK_DATA_WIDTH)
    ) dut0 (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .host_wr_en               (host_wr_en),
        .host_wr_addr             (host_wr_addr),
        .host_wr_data             (host_wr_data),
        .host_rd_en               (host_rd_en),
        .host_rd_addr             (host_rd_addr),
        .host_rd_data             (host_rd_data),
        .cgra_start_pulse         (cgra_start_pulse),
        .cgra_to_io_stall         (cgra_to_io_stall),
        .io_to_cgra_rd_data       (io_to_cgra_rd_data),
        .io_to_cgra_rd_data_valid (io_to_cgra_rd_data_valid),
        .top_config_wr            (top_config_wr),
        .top_config_rd            (top_config_rd),
        .top_config_addr          (top_config_addr),
        .top_config_wr_data       (top_config_wr_data),
        .top_config_rd_data       (top_config_rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_bank_data(input string name, input bank_data_t expected,
                                   input bank_data_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_cgra_data(input string name, input cgra_data_t expected,
                                   input cgra_data_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_cfg_data(input string name, input cfg_data_t expected,
                                  input cfg_data_t actual);
        check_count++;
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // lane 0 is the low 16 bits of the bank word
    function automatic cgra_data_t expected_stream_word(input stream_addr_t addr);
        glb_addr_t g;
        int        lane;
        g    = addr[STREAM_ADDR_WIDTH-1:LANE_WIDTH];
        lane = addr[LANE_WIDTH-1:0];
        return model[g][lane*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
    endfunction

    function automatic cfg_addr_t make_cfg_addr(input logic [3:0] block, input logic [3:0] sel);
        return {block, 4'h0, sel};
    endfunction

    task automatic host_write(input glb_addr_t addr, input bank_data_t data);
        @(negedge clk);
        host_wr_en   = 1'b1;
        host_wr_addr = addr;
        host_wr_data = data;
        model[addr]  = data;
        @(negedge clk);
        host_wr_en = 1'b0;
    endtask

    // word is due one cycle after the read and must hold through an idle cycle
    task automatic host_read_check(input glb_addr_t addr);
        bank_data_t expected;
        @(negedge clk);
        host_rd_en   = 1'b1;
        host_rd_addr = addr;
        expected     = model[addr];
        @(negedge clk);
        host_rd_en = 1'b0;
        check_bank_data("host_rd_data", expected, host_rd_data);
        @(negedge clk);
        check_bank_data("host_rd_data", expected, host_rd_data);
    endtask

    task automatic fill_memory;
        bank_data_t data;
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(negedge clk);
            data         = {$urandom(), 22'h0, 10'(a)};
            host_wr_en   = 1'b1;
            host_wr_addr = glb_addr_t'(a);
            host_wr_data = data;
            model[a]     = data;
        end
        @(negedge clk);
        host_wr_en = 1'b0;
    endtask

    task automatic cfg_write(input logic [3:0] block, input logic [3:0] sel, input cfg_data_t data);
        @(negedge clk);
        top_config_wr      = 1'b1;
        top_config_addr    = make_cfg_addr(block, sel);
        top_config_wr_data = data;
        @(negedge clk);
        top_config_wr = 1'b0;
    endtask

    task automatic cfg_read_check(input logic [3:0] block, input logic [3:0] sel, input logic rd,
                                  input cfg_data_t expected);
        @(negedge clk);
        top_config_rd   = rd;
        top_config_addr = make_cfg_addr(block, sel);
        #2;
        check_cfg_data("top_config_rd_data", expected, top_config_rd_data);
        @(negedge clk);
        top_config_rd = 1'b0;
    endtask

    // restart_at of zero means no second start pulse
    task automatic run_stream(input stream_addr_t start, input int num, input int stall_pct,
                              input int restart_at);
        int got;
        int cycles;
        int limit;
        got    = 0;
        cycles = 0;
        limit  = num * 10 + 50;
        cfg_write(CFG_BLOCK_IO, REG_START_ADDR, cfg_data_t'(start));
        cfg_write(CFG_BLOCK_IO, REG_NUM_WORDS, cfg_data_t'(num));
        @(negedge clk);
        cgra_start_pulse = 1'b1;
        @(negedge clk);
        cgra_start_pulse = 1'b0;
        cgra_to_io_stall = ($urandom() % 100) < stall_pct;
        // a start clears done and sets busy
        top_config_rd    = 1'b1;
        top_config_addr  = make_cfg_addr(CFG_BLOCK_IO, REG_STATUS);
        #2;
        check_cfg_data("top_config_rd_data", 32'h2, top_config_rd_data);
        while (got < num && cycles < limit) begin
            @(negedge clk);
            cycles++;
            cgra_start_pulse = 1'b0;
            top_config_rd    = 1'b0;
            if (io_to_cgra_rd_data_valid) begin
                check_cgra_data("io_to_cgra_rd_data",
                                expected_stream_word(stream_addr_t'(start + got)),
                                io_to_cgra_rd_data);
                got++;
                if (got == restart_at) begin
                    cgra_start_pulse = 1'b1;
                end
            end
            cgra_to_io_stall = ($urandom() % 100) < stall_pct;
        end
        cgra_to_io_stall = 1'b0;
        cgra_start_pulse = 1'b0;
        if (got < num) begin
            protocol_errors++;
            $display("time %0t: stream delivered only %0d of %0d words", $time, got, num);
        end
        repeat (4) begin
            @(negedge clk);
            if (io_to_cgra_rd_data_valid) begin
                protocol_errors++;
                $display("time %0t: unexpected valid after the end of the stream", $time);
            end
        end
        // expect done set and busy clear
        cfg_read_check(CFG_BLOCK_IO, REG_STATUS, 1'b1, 32'h1);
    endtask

    task automatic test_host_access;
        glb_addr_t  addr;
        bank_data_t old_word;
        bank_data_t new_word;
        for (int i = 0; i < 32; i++) begin
            addr = glb_addr_t'((i % NUM_BANKS) * BANK_WORDS + ($urandom() % BANK_WORDS));
            host_write(addr, {$urandom(), $urandom()});
            host_read_check(addr);
        end
        // write and read of one word in the same cycle returns the old word
        addr     = glb_addr_t'(2 * BANK_WORDS + 77);
        old_word = model[addr];
        new_word = {$urandom(), $urandom()};
        @(negedge clk);
        host_wr_en   = 1'b1;
        host_wr_addr = addr;
        host_wr_data = new_word;
        host_rd_en   = 1'b1;
        host_rd_addr = addr;
        @(negedge clk);
        host_wr_en  = 1'b0;
        host_rd_en  = 1'b0;
        model[addr] = new_word;
        check_bank_data("host_rd_data", old_word, host_rd_data);
        host_read_check(addr);
    endtask

    task automatic test_config_registers;
        cfg_read_check(CFG_BLOCK_IO, REG_STATUS, 1'b1, 32'h0);
        cfg_write(CFG_BLOCK_IO, REG_START_ADDR, 32'hffff_f5a3);
        cfg_read_check(CFG_BLOCK_IO, REG_START_ADDR, 1'b1, 32'hffff_f5a3 & STREAM_MASK);
        cfg_write(CFG_BLOCK_IO, REG_NUM_WORDS, 32'h0000_0123);
        cfg_read_check(CFG_BLOCK_IO, REG_NUM_WORDS, 1'b1, 32'h0000_0123 & STREAM_MASK);
        cfg_read_check(CFG_BLOCK_GLB, REG_START_ADDR, 1'b1, 32'h0);
        cfg_read_check(CFG_BLOCK_CFG, REG_NUM_WORDS, 1'b1, 32'h0);
        cfg_read_check(CFG_BLOCK_IO, REG_START_ADDR, 1'b0, 32'h0);
    endtask

    task automatic test_zero_length_stream;
        cfg_write(CFG_BLOCK_IO, REG_NUM_WORDS, 32'h0);
        @(negedge clk);
        cgra_start_pulse = 1'b1;
        @(negedge clk);
        cgra_start_pulse = 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (io_to_cgra_rd_data_valid) begin
                protocol_errors++;
                $display("time %0t: valid seen on a zero-length stream", $time);
            end
        end
        cfg_read_check(CFG_BLOCK_IO, REG_STATUS, 1'b1, 32'h1);
    endtask

    task automatic test_host_read_during_stream;
        glb_addr_t base;
        base = glb_addr_t'(BANK_WORDS + 20);
        fork
            run_stream(stream_addr_t'(base * LANES + 1), 24, 0, 0);
            begin
                repeat (6) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    host_read_check(glb_addr_t'(base + i));
                end
            end
        join
    endtask

    initial begin
        $display("timeout watchdog set to %0d ns", WATCHDOG_NS);
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(32'ha4da50aa));
        clk                = 1'b0;
        rst_n              = 1'b0;
        host_wr_en         = 1'b0;
        host_wr_addr       = '0;
        host_wr_data       = '0;
        host_rd_en         = 1'b0;
        host_rd_addr       = '0;
        cgra_start_pulse   = 1'b0;
        cgra_to_io_stall   = 1'b0;
        top_config_wr      = 1'b0;
        top_config_rd      = 1'b0;
        top_config_addr    = '0;
        top_config_wr_data = '0;
        check_count        = 0;
        mismatch_count     = 0;
        protocol_errors    = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bank_data("host_rd_data", '0, host_rd_data);

        fill_memory();
        test_host_access();
        test_config_registers();
        test_zero_length_stream();
        // crosses from bank 0 into bank 1 and starts on lane 3
        run_stream(stream_addr_t'(250 * LANES + 3), 40, 0, 0);
        run_stream(stream_addr_t'((BANK_WORDS + 240) * LANES + 2), 100, 40, 0);
        // second start pulse mid-stream must not restart the channel
        run_stream(stream_addr_t'((3 * BANK_WORDS + 100) * LANES + 1), 30, 20, 10);
        test_host_read_during_stream();

        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_count, mismatch_count, protocol_errors);
        if (mismatch_count == 0 && protocol_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/global_buffer.sv */
/* Top of the global buffer: host port, NUM_BANKS memory banks, the CGRA
   stream channel and its configuration block, wired together. */
`timescale 1ns/1ps
`default_nettype none

module global_buffer #(
    parameter int NUM_BANKS       = glb_pkg::NUM_BANKS,
    parameter int BANK_ADDR_WIDTH = glb_pkg::BANK_ADDR_WIDTH,
    parameter int BANK_DATA_WIDTH = glb_pkg::BANK_DATA_WIDTH
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                host_wr_en,
    input  glb_pkg::glb_addr_t  host_wr_addr,
    input  glb_pkg::bank_data_t host_wr_data,
    input  logic                host_rd_en,
    input  glb_pkg::glb_addr_t  host_rd_addr,
    output glb_pkg::bank_data_t host_rd_data,

    input  logic                cgra_start_pulse,
    input  logic                cgra_to_io_stall,
    output glb_pkg::cgra_data_t io_to_cgra_rd_data,
    output logic                io_to_cgra_rd_data_valid,

    input  logic                top_config_wr,
    input  logic                top_config_rd,
    input  glb_pkg::cfg_addr_t  top_config_addr,
    input  glb_pkg::cfg_data_t  top_config_wr_data,
    output glb_pkg::cfg_data_t  top_config_rd_data
);

    import glb_pkg::*;

    // host side of the banks
    logic         host_to_bank_wr_en   [NUM_BANKS-1:0];
    bank_addr_t   host_to_bank_wr_addr [NUM_BANKS-1:0];
    bank_data_t   host_to_bank_wr_data [NUM_BANKS-1:0];
    logic         host_to_bank_rd_en   [NUM_BANKS-1:0];
    bank_addr_t   host_to_bank_rd_addr [NUM_BANKS-1:0];
    bank_data_t   bank_to_host_rd_data [NUM_BANKS-1:0];

    // io side of the banks
    logic         io_to_bank_rd_en     [NUM_BANKS-1:0];
    bank_addr_t   io_to_bank_rd_addr   [NUM_BANKS-1:0];
    bank_data_t   bank_to_io_rd_data   [NUM_BANKS-1:0];

    logic         stream_start;
    stream_addr_t stream_start_addr;
    stream_addr_t stream_num_words;
    logic         stream_done;

    host_bank_interconnect #(
        .NUM_BANKS       (NUM_BANKS),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
        .BANK_DATA_WIDTH (BANK_DATA_WIDTH)
    ) u_host_bank_interconnect (
        .clk                  (clk),
        .rst_n                (rst_n),
        .host_wr_en           (host_wr_en),
        .host_wr_addr         (host_wr_addr),
        .host_wr_data         (host_wr_data),
        .host_rd_en           (host_rd_en),
        .host_rd_addr         (host_rd_addr),
        .host_rd_data         (host_rd_data),
        .host_to_bank_wr_en   (host_to_bank_wr_en),
        .host_to_bank_wr_addr (host_to_bank_wr_addr),
        .host_to_bank_wr_data (host_to_bank_wr_data),
        .host_to_bank_rd_en   (host_to_bank_rd_en),
        .host_to_bank_rd_addr (host_to_bank_rd_addr),
        .bank_to_host_rd_data (bank_to_host_rd_data)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
        memory_bank #(
            .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
            .BANK_DATA_WIDTH (BANK_DATA_WIDTH)
        ) u_bank (
            .clk          (clk),
            .rst_n        (rst_n),
            .host_wr_en   (host_to_bank_wr_en[i]),
            .host_wr_addr (host_to_bank_wr_addr[i]),
            .host_wr_data (host_to_bank_wr_data[i]),
            .host_rd_en   (host_to_bank_rd_en[i]),
            .host_rd_addr (host_to_bank_rd_addr[i]),
            .host_rd_data (bank_to_host_rd_data[i]),
            .io_rd_en     (io_to_bank_rd_en[i]),
            .io_rd_addr   (io_to_bank_rd_addr[i]),
            .io_rd_data   (bank_to_io_rd_data[i])
        );
    end

    io_stream_channel #(
        .NUM_BANKS       (NUM_BANKS),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
        .BANK_DATA_WIDTH (BANK_DATA_WIDTH)
    ) u_io_stream_channel (
        .clk                (clk),
        .rst_n              (rst_n),
        .start              (stream_start),
        .start_addr         (stream_start_addr),
        .num_words          (stream_num_words),
        .stall              (cgra_to_io_stall),
        .io_to_bank_rd_en   (io_to_bank_rd_en),
        .io_to_bank_rd_addr (io_to_bank_rd_addr),
        .bank_to_io_rd_data (bank_to_io_rd_data),
        .rd_data            (io_to_cgra_rd_data),
        .rd_data_valid      (io_to_cgra_rd_data_valid),
        .stream_done        (stream_done)
    );

    glb_config_ctrl #(
        .NUM_BANKS       (NUM_BANKS),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH),
        .BANK_DATA_WIDTH (BANK_DATA_WIDTH)
    ) u_glb_config_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .config_wr        (top_config_wr),
        .config_rd        (top_config_rd),
        .config_addr      (top_config_addr),
        .config_wr_data   (top_config_wr_data),
        .config_rd_data   (top_config_rd_data),
        .cgra_start_pulse (cgra_start_pulse),
        .stream_done      (stream_done),
        .start            (stream_start),
        .start_addr       (stream_start_addr),
        .num_words        (stream_num_words)
    );

endmodule

`default_nettype wire

/* verilog/glb_config_ctrl.sv */
/* Configuration bus decoder for the IO block: channel start address, word
   count and status, plus start gating and completion tracking. */
`timescale 1ns/1ps
`default_nettype none

module glb_config_ctrl #(
    parameter int NUM_BANKS       = glb_pkg::NUM_BANKS,
    parameter int BANK_ADDR_WIDTH = glb_pkg::BANK_ADDR_WIDTH,
    parameter int BANK_DATA_WIDTH = glb_pkg::BANK_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  config_wr,
    input  logic                  config_rd,
    input  glb_pkg::cfg_addr_t    config_addr,
    input  glb_pkg::cfg_data_t    config_wr_data,
    output glb_pkg::cfg_data_t    config_rd_data,

    input  logic                  cgra_start_pulse,
    input  logic                  stream_done,
    output logic                  start,
    output glb_pkg::stream_addr_t start_addr,
    output glb_pkg::stream_addr_t num_words
);

    import glb_pkg::*;

    localparam int NUM_BANKS_WIDTH   = $clog2(NUM_BANKS);
    localparam int LANE_WIDTH        = $clog2(BANK_DATA_WIDTH / CGRA_DATA_WIDTH);
    localparam int STREAM_ADDR_WIDTH = NUM_BANKS_WIDTH + BANK_ADDR_WIDTH + LANE_WIDTH;

    cfg_block_e                   block;
    logic [3:0]                   reg_sel;
    logic                         en_io;
    logic [STREAM_ADDR_WIDTH-1:0] start_addr_r;
    logic [STREAM_ADDR_WIDTH-1:0] num_words_r;
    logic                         busy;
    logic                         done;

    assign block   = cfg_block_e'(config_addr[CONFIG_ADDR_WIDTH-1 -: CONFIG_BLOCK_WIDTH]);
    assign reg_sel = config_addr[3:0];
    assign en_io   = (block == CFG_BLOCK_IO);

    // a start while streaming is dropped here
    assign start      = cgra_start_pulse && !busy;
    assign start_addr = start_addr_r;
    assign num_words  = num_words_r;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            start_addr_r <= '0;
            num_words_r  <= '0;
        end else if (config_wr && en_io) begin
            case (reg_sel)
                REG_START_ADDR: start_addr_r <= config_wr_data[STREAM_ADDR_WIDTH-1:0];
                REG_NUM_WORDS:  num_words_r  <= config_wr_data[STREAM_ADDR_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // zero-length stream finishes immediately
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= (num_words_r != '0);
            done <= (num_words_r == '0);
        end else if (stream_done) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    always_comb begin
        config_rd_data = '0;
        if (config_rd && en_io) begin
            case (reg_sel)
                REG_START_ADDR: config_rd_data[STREAM_ADDR_WIDTH-1:0] = start_addr_r;
                REG_NUM_WORDS:  config_rd_data[STREAM_ADDR_WIDTH-1:0] = num_words_r;
                REG_STATUS:     config_rd_data[1:0] = {busy, done};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/io_stream_channel.sv */
/* Streams a region of the buffer to the CGRA as 16-bit words, one bank read
   per unstalled cycle, with the word valid one cycle after its read. */
`timescale 1ns/1ps
`default_nettype none

module io_stream_channel #(
    parameter int NUM_BANKS       = glb_pkg::NUM_BANKS,
    parameter int BANK_ADDR_WIDTH = glb_pkg::BANK_ADDR_WIDTH,
    parameter int BANK_DATA_WIDTH = glb_pkg::BANK_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  start,
    input  glb_pkg::stream_addr_t start_addr,
    input  glb_pkg::stream_addr_t num_words,
    input  logic                  stall,

    output logic                  io_to_bank_rd_en   [NUM_BANKS-1:0],
    output glb_pkg::bank_addr_t   io_to_bank_rd_addr [NUM_BANKS-1:0],
    input  glb_pkg::bank_data_t   bank_to_io_rd_data [NUM_BANKS-1:0],

    output glb_pkg::cgra_data_t   rd_data,
    output logic                  rd_data_valid,
    output logic                  stream_done
);

    import glb_pkg::*;

    localparam int NUM_BANKS_WIDTH   = $clog2(NUM_BANKS);
    localparam int LANE_WIDTH        = $clog2(BANK_DATA_WIDTH / CGRA_DATA_WIDTH);
    localparam int STREAM_ADDR_WIDTH = NUM_BANKS_WIDTH + BANK_ADDR_WIDTH + LANE_WIDTH;

    logic [STREAM_ADDR_WIDTH-1:0] cur_addr;
    logic [STREAM_ADDR_WIDTH-1:0] remaining;
    logic                         active;
    logic                         issue;
    logic                         last_issue;
    logic [NUM_BANKS_WIDTH-1:0]   cur_bank;
    logic [NUM_BANKS_WIDTH-1:0]   bank_q;
    logic [LANE_WIDTH-1:0]        lane_q;
    logic                         last_q;
    bank_data_t                   word;

    assign issue      = active && !stall;
    assign last_issue = issue && (remaining == STREAM_ADDR_WIDTH'(1));
    assign cur_bank   = cur_addr[LANE_WIDTH + BANK_ADDR_WIDTH +: NUM_BANKS_WIDTH];

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            io_to_bank_rd_en[b]   = issue && (cur_bank == NUM_BANKS_WIDTH'(b));
            io_to_bank_rd_addr[b] = cur_addr[LANE_WIDTH +: BANK_ADDR_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active        <= 1'b0;
            cur_addr      <= '0;
            remaining     <= '0;
            rd_data_valid <= 1'b0;
            last_q        <= 1'b0;
            bank_q        <= '0;
            lane_q        <= '0;
        end else begin
            rd_data_valid <= issue;
            last_q        <= last_issue;
            if (issue) begin
                bank_q <= cur_bank;
                lane_q <= cur_addr[LANE_WIDTH-1:0];
            end
            if (start) begin
                cur_addr  <= start_addr;
                remaining <= num_words;
                active    <= (num_words != '0);
            end else if (issue) begin
                cur_addr  <= cur_addr + 1'b1;
                remaining <= remaining - 1'b1;
                active    <= !last_issue;
            end
        end
    end

    // lane 0 is the low 16 bits of the bank word
    assign word        = bank_to_io_rd_data[bank_q];
    assign rd_data     = word[lane_q * CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
    assign stream_done = rd_data_valid && last_q;

endmodule

`default_nettype wire

/* verilog/host_bank_interconnect.sv */
/* Routes host reads and writes to the bank named by the upper address bits
   and returns the read word, held until the next host read completes. */
`timescale 1ns/1ps
`default_nettype none

module host_bank_interconnect #(
    parameter int NUM_BANKS       = glb_pkg::NUM_BANKS,
    parameter int BANK_ADDR_WIDTH = glb_pkg::BANK_ADDR_WIDTH,
    parameter int BANK_DATA_WIDTH = glb_pkg::BANK_DATA_WIDTH
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                host_wr_en,
    input  glb_pkg::glb_addr_t  host_wr_addr,
    input  glb_pkg::bank_data_t host_wr_data,

    input  logic                host_rd_en,
    input  glb_pkg::glb_addr_t  host_rd_addr,
    output glb_pkg::bank_data_t host_rd_data,

    output logic                host_to_bank_wr_en   [NUM_BANKS-1:0],
    output glb_pkg::bank_addr_t host_to_bank_wr_addr [NUM_BANKS-1:0],
    output glb_pkg::bank_data_t host_to_bank_wr_data [NUM_BANKS-1:0],
    output logic                host_to_bank_rd_en   [NUM_BANKS-1:0],
    output glb_pkg::bank_addr_t host_to_bank_rd_addr [NUM_BANKS-1:0],
    input  glb_pkg::bank_data_t bank_to_host_rd_data [NUM_BANKS-1:0]
);

    localparam int NUM_BANKS_WIDTH = $clog2(NUM_BANKS);

    logic [NUM_BANKS_WIDTH-1:0] wr_bank;
    logic [NUM_BANKS_WIDTH-1:0] rd_bank;
    logic [NUM_BANKS_WIDTH-1:0] rd_bank_q;
    logic                       rd_pending;
    logic [BANK_DATA_WIDTH-1:0] rd_hold;

    assign wr_bank = host_wr_addr[BANK_ADDR_WIDTH +: NUM_BANKS_WIDTH];
    assign rd_bank = host_rd_addr[BANK_ADDR_WIDTH +: NUM_BANKS_WIDTH];

    // one-hot bank enables, address and data fan out to all banks
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            host_to_bank_wr_en[b]   = host_wr_en && (wr_bank == NUM_BANKS_WIDTH'(b));
            host_to_bank_wr_addr[b] = host_wr_addr[BANK_ADDR_WIDTH-1:0];
            host_to_bank_wr_data[b] = host_wr_data;
            host_to_bank_rd_en[b]   = host_rd_en && (rd_bank == NUM_BANKS_WIDTH'(b));
            host_to_bank_rd_addr[b] = host_rd_addr[BANK_ADDR_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rd_bank_q  <= '0;
            rd_hold    <= '0;
        end else begin
            rd_pending <= host_rd_en;
            if (host_rd_en) begin
                rd_bank_q <= rd_bank;
            end
            if (rd_pending) begin
                rd_hold <= bank_to_host_rd_data[rd_bank_q];
            end
        end
    end

    // bypass the hold register in the return cycle
    assign host_rd_data = rd_pending ? bank_to_host_rd_data[rd_bank_q] : rd_hold;

endmodule

`default_nettype wire

/* verilog/memory_bank.sv */
/* One bank of the global buffer: a single-clock memory with a host
   read/write port and an independent IO read port. */
`timescale 1ns/1ps
`default_nettype none

module memory_bank #(
    parameter int BANK_ADDR_WIDTH = glb_pkg::BANK_ADDR_WIDTH,
    parameter int BANK_DATA_WIDTH = glb_pkg::BANK_DATA_WIDTH
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                host_wr_en,
    input  glb_pkg::bank_addr_t host_wr_addr,
    input  glb_pkg::bank_data_t host_wr_data,

    input  logic                host_rd_en,
    input  glb_pkg::bank_addr_t host_rd_addr,
    output glb_pkg::bank_data_t host_rd_data,

    input  logic                io_rd_en,
    input  glb_pkg::bank_addr_t io_rd_addr,
    output glb_pkg::bank_data_t io_rd_data
);

    localparam int DEPTH = 2 ** BANK_ADDR_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (host_wr_en) begin
            mem[host_wr_addr] <= host_wr_data;
        end
    end

    // read ports see the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            host_rd_data <= '0;
            io_rd_data   <= '0;
        end else begin
            if (host_rd_en) begin
                host_rd_data <= mem[host_rd_addr];
            end
            if (io_rd_en) begin
                io_rd_data <= mem[io_rd_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/glb_pkg.sv */
/* Shared widths, vector types and configuration codes of the global buffer.
   Modules import it inside their bodies and use scoped names in their headers. */
`default_nettype none

package glb_pkg;

    localparam int NUM_BANKS          = 4;
    localparam int BANK_ADDR_WIDTH    = 8;
    localparam int BANK_DATA_WIDTH    = 64;
    localparam int CGRA_DATA_WIDTH    = 16;
    localparam int CONFIG_ADDR_WIDTH  = 12;
    localparam int CONFIG_DATA_WIDTH  = 32;
    localparam int CONFIG_BLOCK_WIDTH = 4;

    // derived widths
    localparam int NUM_BANKS_WIDTH   = $clog2(NUM_BANKS);
    localparam int GLB_ADDR_WIDTH    = NUM_BANKS_WIDTH + BANK_ADDR_WIDTH;
    localparam int LANE_WIDTH        = $clog2(BANK_DATA_WIDTH / CGRA_DATA_WIDTH);
    localparam int STREAM_ADDR_WIDTH = GLB_ADDR_WIDTH + LANE_WIDTH;

    typedef logic [BANK_ADDR_WIDTH-1:0]   bank_addr_t;
    typedef logic [GLB_ADDR_WIDTH-1:0]    glb_addr_t;
    typedef logic [STREAM_ADDR_WIDTH-1:0] stream_addr_t;
    typedef logic [BANK_DATA_WIDTH-1:0]   bank_data_t;
    typedef logic [CGRA_DATA_WIDTH-1:0]   cgra_data_t;
    typedef logic [CONFIG_ADDR_WIDTH-1:0] cfg_addr_t;
    typedef logic [CONFIG_DATA_WIDTH-1:0] cfg_data_t;

    // block field sits in the top address bits
    typedef enum logic [CONFIG_BLOCK_WIDTH-1:0] {
        CFG_BLOCK_GLB = 4'd0,
        CFG_BLOCK_IO  = 4'd1,
        CFG_BLOCK_CFG = 4'd2
    } cfg_block_e;

    // register offsets inside the IO block
    localparam logic [3:0] REG_START_ADDR = 4'd0;
    localparam logic [3:0] REG_NUM_WORDS  = 4'd1;
    localparam logic [3:0] REG_STATUS     = 4'd2;

endpackage

`default_nettype wire
